/* Makefile */
VERILATOR ?= verilator
TOP       ?= execUnitTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/execUnitTb.sv */
module execUnitTb;

	import aluPkg::*;
	import cpuPkg::*;

	localparam int ClkPeriod = 40;
	localparam int NumRegs = 8;
	localparam int Reps = 8;
	// Reset reads, loads, opR sweep, unknown codes, other classes, write-back, zero
	localparam int NumInstr = 3 * NumRegs - 1 + 10 * Reps + 2 * Reps + 4 * Reps + 2;
	// At most one idle gap per instruction
	localparam int TimeoutCycles = 2 * NumInstr + 20;

	logic     clk;
	logic     rstN;
	logic     issue;
	aluOpT    aluOp;
	funcCodeT funcCode;
	regIdxT   rs;
	regIdxT   rt;
	regIdxT   rd;
	wordT     imm;
	wordT     result;
	logic     resultValid;
	logic     zero;

	integer seed = 72067;
	// Reference register state in program order
	wordT   refRegs [NumRegs];
	// Results still in flight
	wordT   expQ[$];
	string  nameQ[$];

	execUnit #(
		.NumRegs (NumRegs)
	) execUnit_i (
		.clk         (clk),
		.rstN        (rstN),
		.issue       (issue),
		.aluOp       (aluOp),
		.funcCode    (funcCode),
		.rs          (rs),
		.rt          (rt),
		.rd          (rd),
		.imm         (imm),
		.result      (result),
		.resultValid (resultValid),
		.zero        (zero)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input wordT exp, input wordT act);
		if (act !== exp)
			stopWithFailure($sformatf("** Error: %s expected %h actual %h", name, exp, act));
	endtask

	// Result per the operand and decode rules
	function automatic wordT expectResult(aluOpT op, funcCodeT fn, wordT a, wordT rtv,
		wordT immv);
		wordT       b;
		logic [4:0] sh;
		b = (op == opR) ? rtv : immv;
		// Odd shift codes are the variable ones
		sh = (fn == fnSllV || fn == fnSrlV || fn == fnSraV) ? rtv[4:0] : immv[4:0];
		if (op == opR) begin
			case (fn)
				fnSub:          return a - b;
				fnAnd:          return a & b;
				fnXor:          return a ^ b;
				fnSll, fnSllV:  return a << sh;
				fnSrl, fnSrlV:  return a >> sh;
				fnSra, fnSraV:  return wordT'($signed(a) >>> sh);
				default:        return a + b;
			endcase
		end
		if (op == opI && fn == fnSub)
			return a - b;
		return a + b;
	endfunction

	task automatic sendInstr(input string name, input aluOpT op, input funcCodeT fn,
		input regIdxT s, input regIdxT t, input regIdxT d, input wordT im);
		wordT exp;
		exp = expectResult(op, fn, refRegs[s], refRegs[t], im);
		refRegs[d] = exp;
		@(posedge clk);
		issue    <= 1'b1;
		aluOp    <= op;
		funcCode <= fn;
		rs       <= s;
		rt       <= t;
		rd       <= d;
		imm      <= im;
		expQ.push_back(exp);
		nameQ.push_back(name);
	endtask

	// Junk on rd must not write anything
	task automatic idleCycle();
		@(posedge clk);
		issue <= 1'b0;
		rd    <= regIdxT'($random(seed));
	endtask

	// Random operands, sometimes preceded by a gap
	task automatic randomInstr(input string name, input aluOpT op, input funcCodeT fn);
		if (($random(seed) & 3) == 0)
			idleCycle();
		sendInstr(name, op, fn, regIdxT'($random(seed)), regIdxT'($random(seed)),
			regIdxT'($random(seed)), wordT'($random(seed)));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		string name;
		wordT  exp;
		if (rstN && resultValid) begin
			if (expQ.size() == 0) begin
				stopWithFailure("resultValid pulsed with no instruction in flight");
			end else begin
				exp = expQ.pop_front();
				name = nameQ.pop_front();
				checkValue(name, exp, result);
				checkValue({name, " zero"}, wordT'(exp == '0), wordT'(zero));
			end
		end
		if (execUnit_i.execUnitAssertions_i.anyFail)
			stopWithFailure("A concurrent assertion on the DUT failed");
	end

	// Watchdog
	initial begin
		#(TimeoutCycles * ClkPeriod);
		stopWithFailure("Timeout, the instruction sequence did not complete");
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		rstN = 1'b0;
		issue = 1'b0;
		aluOp = opDef;
		funcCode = fnAdd;
		rs = '0;
		rt = '0;
		rd = '0;
		imm = '0;
		for (int r = 0; r < NumRegs; r++)
			refRegs[r] = RegResetVal;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;

		// Reset state of outputs and registers
		@(negedge clk);
		checkValue("reset result", '0, result);
		checkValue("reset valid", '0, wordT'(resultValid));
		checkValue("reset zero", '0, wordT'(zero));
		for (int r = 0; r < NumRegs; r++)
			sendInstr("resetRead", opI, fnAdd, regIdxT'(r), '0, regIdxT'(r), '0);

		// Fill registers through back-to-back immediates
		for (int r = 1; r < NumRegs; r++)
			sendInstr("load", opI, fnAdd, '0, '0, regIdxT'(r), wordT'($random(seed)));

		// Every register function, both codes of each shift pair
		for (int f = 0; f < 10; f++)
			repeat (Reps) randomInstr($sformatf("opR fn%0d", f), opR, funcCodeT'(f));
		repeat (2 * Reps)
			randomInstr("opR unknown", opR, funcCodeT'(10 + {$random(seed)} % 22));

		// Other classes
		repeat (Reps) randomInstr("opI sub", opI, fnSub);
		repeat (Reps) randomInstr("opI", opI, funcCodeT'($random(seed)));
		repeat (Reps) randomInstr("opLs", opLs, funcCodeT'($random(seed)));
		repeat (Reps) randomInstr("opDef", opDef, funcCodeT'($random(seed)));

		// Dependent pair reads the fresh destination
		sendInstr("writeBack", opI, fnAdd, 3'd1, '0, 3'd6, wordT'($random(seed)));
		sendInstr("writeBack", opR, fnXor, 3'd6, 3'd2, 3'd7, '0);

		// Self subtraction forces zero
		for (int r = 0; r < NumRegs; r++)
			sendInstr("zeroFlag", opR, fnSub, regIdxT'(r), regIdxT'(r),
				regIdxT'(NumRegs - 1 - r), '0);
		idleCycle();

		// Wait for the last results, bounded
		for (int i = 0; i < 8 && expQ.size() != 0; i++)
			@(posedge clk);
		if (expQ.size() != 0 || execUnit_i.execUnitAssertions_i.anyFail) begin
			stopWithFailure("Results missing at the end of the run");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* dv/execUnit_assertions.sv */
module execUnitAssertions (
	input logic             clk,
	input logic             rstN,
	input logic             issue,
	input aluPkg::aluOpT    aluOp,
	input aluPkg::funcCodeT funcCode,
	input cpuPkg::regIdxT   rs,
	input cpuPkg::regIdxT   rd,
	input cpuPkg::wordT     rsData,
	input aluPkg::resOpT    resOp,
	input logic             cin,
	input logic             dir,
	input cpuPkg::wordT     aluY,
	input cpuPkg::wordT     result,
	input logic             resultValid,
	input logic             zero
);

	import aluPkg::*;
	import cpuPkg::*;

	// Sticky flag per property so the testbench can poll the OR
	logic validFail = 1'b0;
	logic idleFail = 1'b0;
	logic resetFail = 1'b0;
	logic writeBackFail = 1'b0;
	logic otherDecFail = 1'b0;
	logic regDecFail = 1'b0;
	logic carryFail = 1'b0;
	logic anyFail;

	assign anyFail = validFail | idleFail | resetFail | writeBackFail |
		otherDecFail | regDecFail | carryFail;

	//////////////////////////////////////////////////////////////////////
	// Valid timing and reset state
	//////////////////////////////////////////////////////////////////////

	// Pulse exactly one edge after issue
	validAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
		issue |=> resultValid) else begin
		validFail = 1'b1;
		$error("resultValid missing one cycle after issue");
	end

	// No pulse without an issue
	validOnlyAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
		!issue |=> !resultValid) else begin
		idleFail = 1'b1;
		$error("resultValid high without a preceding issue");
	end

	resetClears: assert property (@(posedge clk)
		!rstN |=> (!resultValid && result == '0 && !zero)) else begin
		resetFail = 1'b1;
		$error("Outputs not cleared by reset");
	end

	//////////////////////////////////////////////////////////////////////
	// Write-back
	//////////////////////////////////////////////////////////////////////

	// Back-to-back reader of the last destination sees the written value
	writeBackVisible: assert property (@(posedge clk) disable iff (!rstN)
		(issue && $past(issue) && rs == $past(rd)) |-> (rsData == $past(aluY)))
		else begin
		writeBackFail = 1'b1;
		$error("Register write-back not visible to the next instruction");
	end

	//////////////////////////////////////////////////////////////////////
	// Decode rules
	//////////////////////////////////////////////////////////////////////

	// Non-register classes add, except the immediate subtract
	otherClassDecode: assert property (@(posedge clk) disable iff (!rstN)
		(aluOp != opR) |->
		(!dir && resOp == ((aluOp == opI && funcCode == fnSub) ? selComp : selAdd)))
		else begin
		otherDecFail = 1'b1;
		$error("Wrong decode for a non-register class");
	end

	// Direction only on logical right, unknown codes add
	regClassDecode: assert property (@(posedge clk) disable iff (!rstN)
		(aluOp == opR) |-> (dir == (funcCode == fnSrl || funcCode == fnSrlV) &&
		(funcCode <= fnSraV || resOp == selAdd))) else begin
		regDecFail = 1'b1;
		$error("Wrong decode for the register class");
	end

	carryForComp: assert property (@(posedge clk) disable iff (!rstN)
		cin == (resOp == selComp)) else begin
		carryFail = 1'b1;
		$error("Carry input set outside of a subtract");
	end

endmodule

bind execUnit execUnitAssertions execUnitAssertions_i (.*);

/* hdl/alu.sv */
module alu (
	input  cpuPkg::wordT              a,
	input  cpuPkg::wordT              b,
	input  logic [aluPkg::ShAmtW-1:0] shAmt,
	input  aluPkg::resOpT             resOp,
	input  logic                      cin,
	input  logic                      dir,
	output cpuPkg::wordT              y
);

	import aluPkg::*;
	import cpuPkg::*;

	// B after optional inversion
	wordT bOp;
	// Shared adder output
	wordT sum;
	// Bitwise unit
	wordT andRes;
	wordT xorRes;
	// Shifter outputs
	wordT shiftLog;
	wordT shiftArith;

	//////////////////////////////////////////////////////////////////////
	// Adder
	//////////////////////////////////////////////////////////////////////

	// Comp inverts B so that A + ~B + 1 is A - B
	assign bOp = (resOp == selComp) ? ~b : b;

	// One adder serves add, subtract and address sums
	assign sum = a + bOp + wordT'(cin);

	//////////////////////////////////////////////////////////////////////
	// Logic unit
	//////////////////////////////////////////////////////////////////////

	assign andRes = a & b;
	assign xorRes = a ^ b;

	//////////////////////////////////////////////////////////////////////
	// Shifter
	//////////////////////////////////////////////////////////////////////

	// Logical shift, dir 1 means right
	assign shiftLog = dir ? (a >> shAmt) : (a << shAmt);

	// Arithmetic right keeps the sign bit
	assign shiftArith = wordT'($signed(a) >>> shAmt);

	//////////////////////////////////////////////////////////////////////
	// Result multiplexer
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (resOp)
			selAdd:    y = sum;
			selComp:   y = sum;
			selAnd:    y = andRes;
			selXor:    y = xorRes;
			selShiftL: y = shiftLog;
			selShiftA: y = shiftArith;
			// Unused select codes behave as add
			default:   y = sum;
		endcase
	end

endmodule

/* hdl/aluControl.sv */
module aluControl (
	input  aluPkg::aluOpT    aluOp,
	input  aluPkg::funcCodeT funcCode,
	output aluPkg::resOpT    resOp,
	output logic             cin,
	output logic             dir
);

	import aluPkg::*;

	//////////////////////////////////////////////////////////////////////
	// Decode table
	//////////////////////////////////////////////////////////////////////

	// Purely combinational decode
	always_comb begin
		// Default is a plain add with no carry
		resOp = selAdd;
		cin   = 1'b0;
		dir   = 1'b0;

		case (aluOp)
			// Address sum for loads and stores
			opLs: begin
				resOp = selAdd;
			end

			// Immediate class knows only add and subtract
			opI: begin
				if (funcCode == fnSub) begin
					resOp = selComp;
					// Carry of 1 completes the two's complement
					cin   = 1'b1;
				end else begin
					resOp = selAdd;
				end
			end

			// Register class follows the full table
			opR: begin
				case (funcCode)
					fnAdd: begin
						resOp = selAdd;
					end
					fnSub: begin
						resOp = selComp;
						cin   = 1'b1;
					end
					fnAnd: begin
						resOp = selAnd;
					end
					fnXor: begin
						resOp = selXor;
					end
					// Logical left
					fnSll, fnSllV: begin
						resOp = selShiftL;
						dir   = 1'b0;
					end
					// Logical right is the only case with dir set
					fnSrl, fnSrlV: begin
						resOp = selShiftL;
						dir   = 1'b1;
					end
					// Arithmetic right, direction is implied
					fnSra, fnSraV: begin
						resOp = selShiftA;
					end
					// Unknown function codes fall back to add
					default: begin
						resOp = selAdd;
					end
				endcase
			end

			// opDef and anything else
			default: begin
				resOp = selAdd;
			end
		endcase
	end

endmodule

/* hdl/aluPkg.sv */
package aluPkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction class
	//////////////////////////////////////////////////////////////////////

	// Two-bit operation class from the decoder
	typedef logic [1:0] aluOpT;

	localparam aluOpT opDef = 2'b00;
	localparam aluOpT opR   = 2'b01;
	localparam aluOpT opI   = 2'b10;
	// Load/store only needs the address sum here
	localparam aluOpT opLs  = 2'b11;

	//////////////////////////////////////////////////////////////////////
	// Function codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [4:0] funcCodeT;

	localparam funcCodeT fnAdd  = 5'd0;
	localparam funcCodeT fnSub  = 5'd1;
	localparam funcCodeT fnAnd  = 5'd2;
	localparam funcCodeT fnXor  = 5'd3;
	// Even code shifts by the immediate, odd code by rt
	localparam funcCodeT fnSll  = 5'd4;
	localparam funcCodeT fnSllV = 5'd5;
	localparam funcCodeT fnSrl  = 5'd6;
	localparam funcCodeT fnSrlV = 5'd7;
	localparam funcCodeT fnSra  = 5'd8;
	localparam funcCodeT fnSraV = 5'd9;

	//////////////////////////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////////////////////////

	typedef logic [2:0] resOpT;

	localparam resOpT selAdd    = 3'b000;
	localparam resOpT selComp   = 3'b001;
	localparam resOpT selAnd    = 3'b010;
	localparam resOpT selXor    = 3'b011;
	localparam resOpT selShiftL = 3'b100;
	localparam resOpT selShiftA = 3'b101;

	// Shift amount covers a full 32-bit word
	localparam int ShAmtW = 5;

endpackage

/* hdl/cpuPkg.sv */
package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////////////////////////

	// Machine word
	localparam int WordW = 32;

	// Register index, sized for the eight-entry file
	localparam int IdxW = 3;

	// Data word on every datapath bus
	typedef logic [WordW-1:0] wordT;

	// Source and destination register index
	typedef logic [IdxW-1:0] regIdxT;

	//////////////////////////////////////////////////////////////////////
	// Reset state
	//////////////////////////////////////////////////////////////////////

	// Value of every register after reset
	localparam wordT RegResetVal = '0;

endpackage

/* hdl/execUnit.sv */
module execUnit #(
	parameter int NumRegs = 8
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             issue,
	input  aluPkg::aluOpT    aluOp,
	input  aluPkg::funcCodeT funcCode,
	input  cpuPkg::regIdxT   rs,
	input  cpuPkg::regIdxT   rt,
	input  cpuPkg::regIdxT   rd,
	input  cpuPkg::wordT     imm,
	output cpuPkg::wordT     result,
	output logic             resultValid,
	output logic             zero
);

	import aluPkg::*;
	import cpuPkg::*;

	// Register file outputs
	wordT rsData;
	wordT rtData;

	// ALU control outputs
	resOpT resOp;
	logic  cin;
	logic  dir;

	// ALU operands and result
	wordT              opB;
	logic [ShAmtW-1:0] shAmt;
	logic              varShift;
	wordT              aluY;

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	// Write-back lands on the issue edge
	regFile #(
		.NumRegs (NumRegs)
	) regFile_i (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rs),
		.rdAddrB (rt),
		.rdDataA (rsData),
		.rdDataB (rtData),
		.wrEn    (issue),
		.wrAddr  (rd),
		.wrData  (aluY)
	);

	//////////////////////////////////////////////////////////////////////
	// Operand selection
	//////////////////////////////////////////////////////////////////////

	// Register class uses rt, every other class the immediate
	assign opB = (aluOp == opR) ? rtData : imm;

	// Odd shift codes take the amount from rt
	assign varShift = (funcCode == fnSllV) || (funcCode == fnSrlV) ||
		(funcCode == fnSraV);

	assign shAmt = varShift ? rtData[ShAmtW-1:0] : imm[ShAmtW-1:0];

	//////////////////////////////////////////////////////////////////////
	// Decode and compute
	//////////////////////////////////////////////////////////////////////

	aluControl aluControl_i (
		.aluOp    (aluOp),
		.funcCode (funcCode),
		.resOp    (resOp),
		.cin      (cin),
		.dir      (dir)
	);

	alu alu_i (
		.a     (rsData),
		.b     (opB),
		.shAmt (shAmt),
		.resOp (resOp),
		.cin   (cin),
		.dir   (dir),
		.y     (aluY)
	);

	//////////////////////////////////////////////////////////////////////
	// Result register
	//////////////////////////////////////////////////////////////////////

	// One cycle latency, valid is a single pulse per issue
	always_ff @(posedge clk) begin
		if (!rstN) begin
			result      <= '0;
			resultValid <= 1'b0;
			zero        <= 1'b0;
		end else begin
			resultValid <= issue;
			// Result and flag hold until the next issue
			if (issue) begin
				result <= aluY;
				zero   <= (aluY == '0);
			end
		end
	end

endmodule

/* hdl/regFile.sv */
module regFile #(
	parameter int NumRegs = 8
) (
	input  logic           clk,
	input  logic           rstN,
	input  cpuPkg::regIdxT rdAddrA,
	input  cpuPkg::regIdxT rdAddrB,
	output cpuPkg::wordT   rdDataA,
	output cpuPkg::wordT   rdDataB,
	input  logic           wrEn,
	input  cpuPkg::regIdxT wrAddr,
	input  cpuPkg::wordT   wrData
);

	import cpuPkg::*;

	// Register array
	wordT regs [NumRegs];

	//////////////////////////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////////////////////////

	// Both reads are combinational
	// A read in the same cycle as a write sees the old value
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			// Whole file returns to a known state
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= RegResetVal;
			end
		end else if (wrEn) begin
			// One entry per enabled edge
			regs[wrAddr] <= wrData;
		end
	end

endmodule

/* src.f */
hdl/aluPkg.sv
hdl/cpuPkg.sv
hdl/aluControl.sv
hdl/alu.sv
hdl/regFile.sv
hdl/execUnit.sv
dv/execUnit_assertions.sv
dv/execUnitTb.sv
